/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // ------------------------------
  // Instruction word fields
  // ------------------------------

  // Raw 32-bit instruction
  typedef logic [31:0] instr_t;

  // Minor operation field, bits 14:12
  typedef logic [2:0] funct3_t;

  // Register index for rd, rs1 and rs2
  typedef logic [4:0] reg_idx_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // ------------------------------
  // Branch funct3 codes
  // ------------------------------
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // ------------------------------
  // ALU funct3 codes
  // ------------------------------
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  // SRL and SRA share a code, bit 30 picks arithmetic
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Word width code for LW and SW
  localparam funct3_t F3_WORD = 3'b010;

  // Whole-word encodings
  localparam instr_t I_EBREAK = 32'h0010_0073;
  // addi x0, x0, 0
  localparam instr_t I_NOP    = 32'h0000_0013;

endpackage

`default_nettype wire

/* source/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  // ------------------------------
  // Datapath types
  // ------------------------------

  // Data and address word
  typedef logic [31:0] word_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // Immediate straight through, used by LUI
    ALU_PASS_B
  } alu_op_t;

  // ALU A operand source
  typedef enum logic [1:0] {
    A_REG,
    A_ZERO,
    A_PC
  } a_src_t;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_t;

  // ------------------------------
  // Decoded control, one instruction
  // ------------------------------
  typedef struct packed {
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    a_src_t               a_src;
    // B operand is imm instead of rs2
    logic                 b_imm;
    alu_op_t              alu_op;
    res_src_t             res_src;
    logic                 is_branch;
    logic                 is_jump;
    logic                 is_jalr;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    word_t                imm;
  } ctrl_t;

endpackage

`default_nettype wire

/* source/rv_fetch.sv */
`default_nettype none

module rv_fetch #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               redirect,
  input  rv_core_pkg::word_t target,
  output rv_core_pkg::word_t pc
);

  import rv_core_pkg::*;

  // Sequential address and chosen next PC
  word_t pc_seq;
  word_t pc_next;

  // ------------------------------
  // Next PC selection
  // ------------------------------

  assign pc_seq = pc + 32'd4;

  // Taken branch or jump wins over fall-through
  always_comb begin
    if (redirect) begin
      pc_next = target;
    end else begin
      pc_next = pc_seq;
    end
  end

  // ------------------------------
  // PC register
  // ------------------------------

  // One update per clock, no stalls in a single-cycle core
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* source/rv_decode.sv */
`default_nettype none

module rv_decode (
  input  rv_isa_pkg::instr_t  instr,
  output rv_core_pkg::ctrl_t  ctrl
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  // ALU op from funct3, sub and sra pick the alternate forms
  function automatic alu_op_t alu_sel(input funct3_t f3, input logic sub, input logic sra);
    case (f3)
      F3_ADD:  alu_sel = sub ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_sel = ALU_SLL;
      F3_SLT:  alu_sel = ALU_SLT;
      F3_SLTU: alu_sel = ALU_SLTU;
      F3_XOR:  alu_sel = ALU_XOR;
      F3_SR:   alu_sel = sra ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_t'(instr[6:0]);

  // ------------------------------
  // Immediate formats
  // ------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ------------------------------
  // Control decode
  // ------------------------------
  always_comb begin
    // Default is a no-op with no side effects
    ctrl        = '0;
    ctrl.funct3 = instr[14:12];
    ctrl.rd     = instr[11:7];
    ctrl.rs1    = instr[19:15];
    ctrl.rs2    = instr[24:20];

    case (opcode)
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.imm       = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src     = A_PC;
        ctrl.b_imm     = 1'b1;
        ctrl.imm       = imm_u;
      end
      OPC_JAL: begin
        // Link is PC+4, target from the PC-relative adder
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jump   = 1'b1;
        ctrl.imm       = imm_j;
      end
      OPC_JALR: begin
        // ALU forms rs1 + imm for the target
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jump   = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.imm       = imm_i;
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
      end
      OPC_LOAD: begin
        // Word loads only
        if (instr[14:12] == F3_WORD) begin
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.res_src   = RES_MEM;
          ctrl.b_imm     = 1'b1;
          ctrl.imm       = imm_i;
        end
      end
      OPC_STORE: begin
        if (instr[14:12] == F3_WORD) begin
          ctrl.mem_write = 1'b1;
          ctrl.b_imm     = 1'b1;
          ctrl.imm       = imm_s;
        end
      end
      OPC_OP_IMM: begin
        // No SUB form, bit 30 only selects SRAI
        ctrl.reg_write = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.alu_op    = alu_sel(instr[14:12], 1'b0, instr[30]);
        ctrl.imm       = imm_i;
      end
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sel(instr[14:12], instr[30], instr[30]);
      end
      // SYSTEM and anything unknown stay a no-op
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`default_nettype none

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  logic                 rd_en,
  input  rv_core_pkg::word_t   rd_data,
  output rv_core_pkg::word_t   rs1_data,
  output rv_core_pkg::word_t   rs2_data
);

  import rv_core_pkg::*;

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  // Write port, x0 writes dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd != 5'd0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Combinational read ports
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* source/rv_execute.sv */
`default_nettype none

module rv_execute (
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::word_t pc,
  input  rv_core_pkg::word_t rs1_data,
  input  rv_core_pkg::word_t rs2_data,
  output rv_core_pkg::word_t alu_result,
  output rv_core_pkg::word_t store_data,
  output logic               redirect,
  output rv_core_pkg::word_t target
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t alu_a;
  word_t alu_b;
  word_t pc_rel;
  logic  taken;

  // ------------------------------
  // Operand selection
  // ------------------------------
  always_comb begin
    case (ctrl.a_src)
      A_ZERO:  alu_a = '0;
      A_PC:    alu_a = pc;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = ctrl.b_imm ? ctrl.imm : rs2_data;

  // ------------------------------
  // ALU
  // ------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      // Shift amount is the low five bits
      ALU_SLL:    alu_result = alu_a << alu_b[4:0];
      ALU_SRL:    alu_result = alu_a >> alu_b[4:0];
      ALU_SRA:    alu_result = word_t'($signed(alu_a) >>> alu_b[4:0]);
      ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_result = {31'b0, alu_a < alu_b};
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // Store data is rs2 unchanged, word stores only
  assign store_data = rs2_data;

  // ------------------------------
  // Branch compare
  // ------------------------------
  // Always on the raw register values
  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // ------------------------------
  // Jump and branch target
  // ------------------------------
  assign pc_rel = pc + ctrl.imm;

  // JALR clears bit 0 of rs1 + imm
  assign target = ctrl.is_jalr ? {alu_result[31:1], 1'b0} : pc_rel;

  assign redirect = ctrl.is_jump || (ctrl.is_branch && taken);

endmodule

`default_nettype wire

/* source/rv_mem_wb.sv */
`default_nettype none

module rv_mem_wb (
  input  logic               rst,
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::word_t pc,
  input  rv_core_pkg::word_t alu_result,
  input  rv_core_pkg::word_t store_data,
  input  rv_core_pkg::word_t dmem_rdata,
  output logic               dmem_ren,
  output rv_core_pkg::word_t dmem_raddr,
  output logic               dmem_we,
  output rv_core_pkg::word_t dmem_waddr,
  output rv_core_pkg::word_t dmem_wdata,
  output rv_core_pkg::word_t wb_data
);

  import rv_core_pkg::*;

  // ------------------------------
  // Data memory port
  // ------------------------------
  // Address from the ALU sum, enables held low in reset
  assign dmem_ren   = ctrl.mem_read && !rst;
  assign dmem_raddr = alu_result;

  assign dmem_we    = ctrl.mem_write && !rst;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = store_data;

  // ------------------------------
  // Write-back select
  // ------------------------------
  always_comb begin
    case (ctrl.res_src)
      RES_MEM: wb_data = dmem_rdata;
      // Link value for JAL and JALR
      RES_PC4: wb_data = pc + 32'd4;
      default: wb_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`default_nettype none

module rv_core #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst,

  // Instruction memory, combinational read
  output rv_core_pkg::word_t imem_raddr,
  input  rv_isa_pkg::instr_t imem_rdata,

  // Data memory read
  output logic               dmem_ren,
  output rv_core_pkg::word_t dmem_raddr,
  input  rv_core_pkg::word_t dmem_rdata,

  // Data memory write, taken at the clock edge
  output logic               dmem_we,
  output rv_core_pkg::word_t dmem_waddr,
  output rv_core_pkg::word_t dmem_wdata,

  output logic               ebreak
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t pc;
  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t store_data;
  logic  redirect;
  word_t target;
  word_t wb_data;

  // ------------------------------
  // Fetch
  // ------------------------------
  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) fetch (
    .clk     (clk),
    .rst     (rst),
    .redirect(redirect),
    .target  (target),
    .pc      (pc)
  );

  assign imem_raddr = pc;

  // ------------------------------
  // Decode and register read
  // ------------------------------
  rv_decode decode (
    .instr(imem_rdata),
    .ctrl (ctrl)
  );

  // Write-back lands at the end of the same cycle
  rv_regfile regfile (
    .clk     (clk),
    .rst     (rst),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rd      (ctrl.rd),
    .rd_en   (ctrl.reg_write),
    .rd_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // ------------------------------
  // Execute, memory, write-back
  // ------------------------------
  rv_execute execute (
    .ctrl      (ctrl),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .alu_result(alu_result),
    .store_data(store_data),
    .redirect  (redirect),
    .target    (target)
  );

  rv_mem_wb mem_wb (
    .rst       (rst),
    .ctrl      (ctrl),
    .pc        (pc),
    .alu_result(alu_result),
    .store_data(store_data),
    .dmem_rdata(dmem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .wb_data   (wb_data)
  );

  // Halt flag straight off the fetched word
  assign ebreak = !rst && (imem_rdata == I_EBREAK);

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] CLK_PERIOD = 100;
  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam int          RST_CYCLES = 4;
  localparam int          IMEM_WORDS = 256;
  localparam int          DMEM_WORDS = 256;
  localparam int          STIM_WORDS = 512;

  logic        clk;
  logic        rst;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;

  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] stim [0:STIM_WORDS-1];

  // Expected writes from the data file, tagged with their test number
  int          exp_tag [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  // Writes seen on the data memory port
  logic [31:0] got_addr [$];
  logic [31:0] got_data [$];

  int          prog_words;
  logic [31:0] final_pc;
  logic        loaded;
  int          errors;
  int          tests_run;
  int          tests_failed;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .ebreak    (ebreak)
  );

  // ------------------------------
  // Memory models
  // ------------------------------
  // Unknown PC before the first edge reads as a no-op
  assign imem_rdata = ($isunknown(imem_raddr)) ? 32'h0000_0013 : imem[imem_raddr[9:2]];
  assign dmem_rdata = ($isunknown(dmem_raddr)) ? 32'h0 : dmem[dmem_raddr[9:2]];

  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // Clock
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Checks and reporting
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
  endtask

  // Compare every expected write of one test against the capture at the same position
  task automatic compare_writes(input int tag);
    for (int i = 0; i < exp_tag.size(); i++) begin
      if (exp_tag[i] == tag) begin
        if (i < got_addr.size()) begin
          check_value($sformatf("dmem_waddr[%0d]", i), got_addr[i], exp_addr[i]);
          check_value($sformatf("dmem_wdata[%0d]", i), got_data[i], exp_data[i]);
        end else begin
          report_problem($sformatf("write %0d to address 0x%08h never happened",
                                   i, exp_addr[i]));
        end
      end
    end
  endtask

  // Stimulus file into memories and expected lists
  task automatic load_stimulus();
    int p;
    int n_writes;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      // Unknown opcode 7F in every word, upper bits from the index
      imem[i] = {i[24:0], 7'h7F};
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'hD000_0000 ^ (i * 32'h9E37_79B1);
    end
    $readmemh("bench/program_input.txt", stim);
    p = 0;
    prog_words = stim[p];
    p++;
    for (int i = 0; i < prog_words; i++) begin
      imem[(RESET_PC >> 2) + i] = stim[p];
      p++;
    end
    n_writes = stim[p];
    p++;
    for (int i = 0; i < n_writes; i++) begin
      exp_tag.push_back(int'(stim[p]));
      exp_addr.push_back(stim[p + 1]);
      exp_data.push_back(stim[p + 2]);
      p += 3;
    end
    final_pc = stim[p];
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    int limit;
    wait (loaded === 1'b1);
    limit = RST_CYCLES + prog_words + 20;
    repeat (limit) @(posedge clk);
    $display("timeout: ebreak never rose within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int   errs_before;
    logic exp_ren;
    rst          = 1'b1;
    loaded       = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_stimulus();
    loaded = 1'b1;

    // Reset state, sampled on a falling edge
    repeat (RST_CYCLES) @(negedge clk);
    errs_before = errors;
    check_value("imem_raddr", imem_raddr, RESET_PC);
    check_value("dmem_we", {31'b0, dmem_we}, 32'h0);
    check_value("ebreak", {31'b0, ebreak}, 32'h0);
    close_test("reset", errs_before);
    rst = 1'b0;

    // Fetch alignment and read enable, every cycle up to the halt
    errs_before = errors;
    // Sample a quarter period after each falling edge
    forever begin
      #(CLK_PERIOD / 4);
      if (imem_raddr[1:0] != 2'b00) begin
        report_problem($sformatf("fetch from misaligned address 0x%08h", imem_raddr));
      end
      // Read enable only for LW, load opcode with word width
      exp_ren = (imem_rdata[6:0] == 7'b000_0011) && (imem_rdata[14:12] == 3'b010);
      check_value("dmem_ren", {31'b0, dmem_ren}, {31'b0, exp_ren});
      if (dmem_we === 1'b1) begin
        got_addr.push_back(dmem_waddr);
        got_data.push_back(dmem_wdata);
      end
      if (ebreak === 1'b1) begin
        break;
      end
      @(negedge clk);
    end
    close_test("execution", errs_before);

    errs_before = errors;
    compare_writes(2);
    close_test("alu", errs_before);

    errs_before = errors;
    compare_writes(3);
    close_test("load", errs_before);

    errs_before = errors;
    compare_writes(4);
    close_test("branch", errs_before);

    errs_before = errors;
    compare_writes(5);
    close_test("jump", errs_before);

    // Halt point and total write count
    errs_before = errors;
    check_value("imem_raddr", imem_raddr, final_pc);
    check_value("write count", got_addr.size(), exp_addr.size());
    close_test("halt", errs_before);

    $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/program_input.txt */
// Word count, program words from address 0, write count,
// then test/address/data per expected write, then the final PC
00000033
// ALU: base x10, x1 = -7, x2 = 3, sub, sll, srai, srli, slt, sltu
10000513 FF900093 00300113 402081B3
00352023 00211233 00452223 4010D293
00552423 01C0D313 00652623 0020A3B3
0020B433 00752823 00852A23
// Load, add 100, store back
00052583 06458593 00B52C23
// Branch pairs taken then not taken: beq bne blt bge bltu bgeu
00210463 02252E23 00208463 00252E23
00209463 02252E23 00211463 02252023
0020C463 02252E23 00114463 02252223
00115463 02252E23 0020D463 02252423
00116463 02252E23 0020E463 02252623
0020F463 02252E23 00117463 02252823
// JAL with link store, JALR to an odd address with link store
0080076F 02252E23 02E52A23 0C500793
00078867 02252E23 02252E23 03052C23
// Halt
00100073
0000000F
00000002 00000100 FFFFFFF6
00000002 00000104 00000018
00000002 00000108 FFFFFFFC
00000002 0000010C 0000000F
00000002 00000110 00000001
00000002 00000114 00000000
00000003 00000118 0000005A
00000004 0000011C 00000003
00000004 00000120 00000003
00000004 00000124 00000003
00000004 00000128 00000003
00000004 0000012C 00000003
00000004 00000130 00000003
00000005 00000134 000000AC
00000005 00000138 000000BC
000000C8

/* sources.f */
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_mem_wb.sv
source/rv_core.sv
bench/rv_core_tb.sv

/* Makefile */
TOP = rv_core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the pass message shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
